//--- src/cpu_pkg.sv
package cpu_pkg;

	////////////////////
	// Instruction encodings

	// Primary opcode field, instr[31:26]
	typedef enum logic [5:0]
	{
		OP_RTYPE = 6'h00,
		OP_ADDI  = 6'h08,
		OP_ANDI  = 6'h0c,
		OP_ORI   = 6'h0d
	} opcode_e;

	// R-type function field, instr[5:0]
	typedef enum logic [5:0]
	{
		FN_ADD = 6'h20,
		FN_SUB = 6'h22,
		FN_AND = 6'h24,
		FN_OR  = 6'h25,
		FN_SLT = 6'h2a
	} funct_e;

	////////////////////
	// Internal ALU operations

	typedef enum logic [2:0]
	{
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_SLT
	} alu_op_e;

	////////////////////
	// Register bank contents after init

	localparam logic [31:0] REG_PRESET [0:31] = '{
		32'd2,  32'd0,  32'd2,  32'd5,  32'd2,  32'd5,  32'd0,  32'd0,
		32'd3,  32'd0,  32'd0,  32'd0,  32'd0,  32'd0,  32'd0,  32'd80,
		32'd0,  32'd0,  32'd0,  32'd0,  32'd0,  32'd0,  32'd0,  32'd0,
		32'd0,  32'd0,  32'd0,  32'd0,  32'd0,  32'd0,  32'd0,  32'd0
	};

endpackage

//--- src/register_file.sv
`timescale 1ns/10ps

module register_file
	import cpu_pkg::*;
(
	input  logic        clk,
	input  logic        init,
	input  logic [4:0]  rs_addr,
	input  logic [4:0]  rt_addr,
	input  logic [4:0]  dbg_addr,
	input  logic        we,
	input  logic [4:0]  wa,
	input  logic [31:0] wd,
	output logic [31:0] rd1,
	output logic [31:0] rd2,
	output logic [31:0] dbg_data
);

	logic [31:0] bank [0:31];

	////////////////////
	// Write side

	// Falling edge, so a result written this cycle is visible to
	// decode before the next rising edge
	always_ff @(negedge clk)
	begin
		if (init)
		begin
			for (int i = 0; i < 32; i++)
			begin
				bank[i] <= REG_PRESET[i];
			end
		end
		else if (we)
		begin
			bank[wa] <= wd;
		end
	end

	////////////////////
	// Read side

	// Operand ports for decode
	assign rd1 = bank[rs_addr];
	assign rd2 = bank[rt_addr];

	// Debug port
	assign dbg_data = bank[dbg_addr];

	// Init may only be raised with the pipeline drained
	a_no_write_during_init : assert property (
		@(negedge clk) !(we && init)
	) else $error("register write while init is high");

endmodule

//--- src/decode_stage.sv
`timescale 1ns/10ps

module decode_stage
	import cpu_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  logic [31:0] instr,
	input  logic        instr_valid,
	input  logic [31:0] rd1,
	input  logic [31:0] rd2,
	output logic [4:0]  rs_addr,
	output logic [4:0]  rt_addr,
	output logic        d_valid,
	output logic        d_illegal,
	output alu_op_e     d_alu_op,
	output logic [4:0]  d_rs_addr,
	output logic [4:0]  d_rt_addr,
	output logic        d_use_imm,
	output logic [31:0] d_imm,
	output logic [4:0]  d_dest,
	output logic [31:0] d_a,
	output logic [31:0] d_b
);

	alu_op_e     dec_alu_op;
	logic        dec_use_imm;
	logic [31:0] dec_imm;
	logic [4:0]  dec_dest;
	logic        dec_known;

	// Source addresses go straight to the register file
	assign rs_addr = instr[25:21];
	assign rt_addr = instr[20:16];

	////////////////////
	// Field decode

	always_comb
	begin
		dec_alu_op  = ALU_ADD;
		dec_use_imm = 1'b0;
		dec_imm     = 32'd0;
		dec_dest    = instr[15:11];
		dec_known   = 1'b1;
		case (opcode_e'(instr[31:26]))
			OP_RTYPE:
			begin
				case (funct_e'(instr[5:0]))
					FN_ADD:  dec_alu_op = ALU_ADD;
					FN_SUB:  dec_alu_op = ALU_SUB;
					FN_AND:  dec_alu_op = ALU_AND;
					FN_OR:   dec_alu_op = ALU_OR;
					FN_SLT:  dec_alu_op = ALU_SLT;
					default: dec_known = 1'b0;
				endcase
			end
			OP_ADDI:
			begin
				dec_alu_op  = ALU_ADD;
				dec_use_imm = 1'b1;
				dec_imm     = {{16{instr[15]}}, instr[15:0]};
				dec_dest    = instr[20:16];
			end
			// Logical immediates are zero-extended
			OP_ANDI, OP_ORI:
			begin
				dec_alu_op  = (instr[31:26] == OP_ANDI) ? ALU_AND : ALU_OR;
				dec_use_imm = 1'b1;
				dec_imm     = {16'd0, instr[15:0]};
				dec_dest    = instr[20:16];
			end
			default: dec_known = 1'b0;
		endcase
	end

	////////////////////
	// Decode register

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			d_valid   <= 1'b0;
			d_illegal <= 1'b0;
		end
		else
		begin
			d_valid   <= instr_valid && dec_known;
			d_illegal <= instr_valid && !dec_known;
		end
	end

	always_ff @(posedge clk)
	begin
		if (instr_valid)
		begin
			d_alu_op  <= dec_alu_op;
			d_rs_addr <= rs_addr;
			d_rt_addr <= rt_addr;
			d_use_imm <= dec_use_imm;
			d_imm     <= dec_imm;
			d_dest    <= dec_dest;
			d_a       <= rd1;
			d_b       <= rd2;
		end
	end

	a_valid_or_illegal : assert property (
		@(posedge clk) disable iff (rst) !(d_valid && d_illegal)
	) else $error("decode flagged an instruction both valid and illegal");

endmodule

//--- src/execute_stage.sv
`timescale 1ns/10ps

module execute_stage
	import cpu_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  logic        d_valid,
	input  logic        d_illegal,
	input  alu_op_e     d_alu_op,
	input  logic [4:0]  d_rs_addr,
	input  logic [4:0]  d_rt_addr,
	input  logic        d_use_imm,
	input  logic [31:0] d_imm,
	input  logic [4:0]  d_dest,
	input  logic [31:0] d_a,
	input  logic [31:0] d_b,
	output logic        wb_valid,
	output logic [4:0]  wb_addr,
	output logic [31:0] wb_data,
	output logic        illegal
);

	logic        fwd_a;
	logic        fwd_b;
	logic [31:0] op_a;
	logic [31:0] op_b;
	logic [31:0] reg_b;
	logic [31:0] alu_result;

	////////////////////
	// Operand forwarding

	// Only the instruction directly ahead can be stale in decode
	assign fwd_a = wb_valid && (wb_addr == d_rs_addr);
	assign fwd_b = wb_valid && (wb_addr == d_rt_addr);

	assign op_a  = fwd_a ? wb_data : d_a;
	assign reg_b = fwd_b ? wb_data : d_b;
	assign op_b  = d_use_imm ? d_imm : reg_b;

	////////////////////
	// ALU

	always_comb
	begin
		case (d_alu_op)
			ALU_ADD: alu_result = op_a + op_b;
			ALU_SUB: alu_result = op_a - op_b;
			ALU_AND: alu_result = op_a & op_b;
			ALU_OR:  alu_result = op_a | op_b;
			// Signed compare
			ALU_SLT: alu_result = ($signed(op_a) < $signed(op_b)) ? 32'd1 : 32'd0;
			default: alu_result = 32'd0;
		endcase
	end

	////////////////////
	// Writeback register

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wb_valid <= 1'b0;
			illegal  <= 1'b0;
		end
		else
		begin
			wb_valid <= d_valid;
			illegal  <= d_illegal;
		end
	end

	always_ff @(posedge clk)
	begin
		if (d_valid)
		begin
			wb_addr <= d_dest;
			wb_data <= alu_result;
		end
	end

	a_pulse_exclusive : assert property (
		@(posedge clk) disable iff (rst) !(wb_valid && illegal)
	) else $error("wb_valid and illegal high together");

endmodule

//--- src/pipeline_top.sv
`timescale 1ns/10ps

module pipeline_top
	import cpu_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  logic        init,
	input  logic [31:0] instr,
	input  logic        instr_valid,
	input  logic [4:0]  dbg_addr,
	output logic        wb_valid,
	output logic [4:0]  wb_addr,
	output logic [31:0] wb_data,
	output logic        illegal,
	output logic [31:0] dbg_data
);

	// Register file read side
	logic [4:0]  rs_addr;
	logic [4:0]  rt_addr;
	logic [31:0] rd1;
	logic [31:0] rd2;

	// Decode to execute
	logic        d_valid;
	logic        d_illegal;
	alu_op_e     d_alu_op;
	logic [4:0]  d_rs_addr;
	logic [4:0]  d_rt_addr;
	logic        d_use_imm;
	logic [31:0] d_imm;
	logic [4:0]  d_dest;
	logic [31:0] d_a;
	logic [31:0] d_b;

	decode_stage u_decode (
		.clk         (clk),
		.rst         (rst),
		.instr       (instr),
		.instr_valid (instr_valid),
		.rd1         (rd1),
		.rd2         (rd2),
		.rs_addr     (rs_addr),
		.rt_addr     (rt_addr),
		.d_valid     (d_valid),
		.d_illegal   (d_illegal),
		.d_alu_op    (d_alu_op),
		.d_rs_addr   (d_rs_addr),
		.d_rt_addr   (d_rt_addr),
		.d_use_imm   (d_use_imm),
		.d_imm       (d_imm),
		.d_dest      (d_dest),
		.d_a         (d_a),
		.d_b         (d_b)
	);

	execute_stage u_execute (
		.clk       (clk),
		.rst       (rst),
		.d_valid   (d_valid),
		.d_illegal (d_illegal),
		.d_alu_op  (d_alu_op),
		.d_rs_addr (d_rs_addr),
		.d_rt_addr (d_rt_addr),
		.d_use_imm (d_use_imm),
		.d_imm     (d_imm),
		.d_dest    (d_dest),
		.d_a       (d_a),
		.d_b       (d_b),
		.wb_valid  (wb_valid),
		.wb_addr   (wb_addr),
		.wb_data   (wb_data),
		.illegal   (illegal)
	);

	// Writeback group doubles as the write port
	register_file u_regs (
		.clk      (clk),
		.init     (init),
		.rs_addr  (rs_addr),
		.rt_addr  (rt_addr),
		.dbg_addr (dbg_addr),
		.we       (wb_valid),
		.wa       (wb_addr),
		.wd       (wb_data),
		.rd1      (rd1),
		.rd2      (rd2),
		.dbg_data (dbg_data)
	);

endmodule

//--- test/tb_checker.sv
`timescale 1ns/10ps

module tb_checker
	import cpu_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  logic        init,
	input  logic [31:0] instr,
	input  logic        exp_strobe,
	input  logic [31:0] exp_data,
	input  logic        wb_valid,
	input  logic [4:0]  wb_addr,
	input  logic [31:0] wb_data,
	input  logic        illegal,
	input  logic        dbg_strobe,
	input  logic [4:0]  dbg_addr,
	input  logic [31:0] dbg_data,
	output int          errors,
	output int          checks,
	output int          pending
);

	// Outstanding instructions with the oldest at the front
	int          due_q [$];
	logic [31:0] instr_q [$];
	logic [31:0] data_q [$];

	logic [31:0] shadow [0:31];
	int          cycle;
	int          due_now;
	logic [31:0] instr_now;
	logic [31:0] data_now;
	logic [4:0]  dest_now;

	initial
	begin
		errors  = 0;
		checks  = 0;
		pending = 0;
		cycle   = 0;
		for (int i = 0; i < 32; i++)
		begin
			shadow[i] = REG_PRESET[i];
		end
	end

	////////////////////
	// Reference rules

	// True for the codes the pipeline executes
	function automatic logic known_code(input logic [31:0] ins);
		logic known;
		case (ins[31:26])
			OP_RTYPE:
			begin
				case (ins[5:0])
					FN_ADD, FN_SUB, FN_AND, FN_OR, FN_SLT: known = 1'b1;
					default: known = 1'b0;
				endcase
			end
			OP_ADDI, OP_ANDI, OP_ORI: known = 1'b1;
			default: known = 1'b0;
		endcase
		return known;
	endfunction

	// Destination is rd for R-type and rt for I-type
	function automatic logic [4:0] dest_of(input logic [31:0] ins);
		return (ins[31:26] == OP_RTYPE) ? ins[15:11] : ins[20:16];
	endfunction

	task automatic check_value(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		checks++;
		if (act !== exp)
		begin
			$display("** Error %s: expected %h, got %h", name, exp, act);
			errors++;
		end
	endtask

	////////////////////
	// Pulse and readback checks

	always @(posedge clk)
	begin
		cycle++;
		if (!rst)
		begin
			if (init)
			begin
				for (int i = 0; i < 32; i++)
				begin
					shadow[i] = REG_PRESET[i];
				end
			end
			if (wb_valid || illegal)
			begin
				if (due_q.size() == 0)
				begin
					$display("unexpected pulse with no instruction outstanding, cycle %0d",
						cycle);
					errors++;
				end
				else
				begin
					due_now   = due_q.pop_front();
					instr_now = instr_q.pop_front();
					data_now  = data_q.pop_front();
					dest_now  = dest_of(instr_now);
					if (due_now != cycle)
					begin
						$display("pulse for instruction %h at cycle %0d, due at cycle %0d",
							instr_now, cycle, due_now);
						errors++;
					end
					if (!known_code(instr_now))
					begin
						checks++;
						if (wb_valid)
						begin
							$display("instruction %h is unknown but gave a writeback",
								instr_now);
							errors++;
						end
					end
					else if (illegal)
					begin
						$display("instruction %h was flagged illegal", instr_now);
						errors++;
					end
					else
					begin
						check_value("wb_addr", {27'd0, dest_now}, {27'd0, wb_addr});
						check_value("wb_data", data_now, wb_data);
						shadow[dest_now] = data_now;
					end
				end
			end
			else if (due_q.size() != 0 && due_q[0] <= cycle)
			begin
				$display("no pulse for instruction %h by cycle %0d", instr_q[0], cycle);
				errors++;
				due_q.delete(0);
				instr_q.delete(0);
				data_q.delete(0);
			end
			// Pulse is due two edges after the strobe is sampled
			if (exp_strobe)
			begin
				due_q.push_back(cycle + 2);
				instr_q.push_back(instr);
				data_q.push_back(exp_data);
			end
			if (dbg_strobe)
			begin
				check_value($sformatf("dbg_data[%0d]", dbg_addr), shadow[dbg_addr], dbg_data);
			end
		end
		pending = due_q.size();
	end

endmodule

//--- test/tb_pipeline.sv
`timescale 1ns/10ps

module tb_pipeline
	import cpu_pkg::*;
;

	logic        clk;
	logic        rst;
	logic        init;
	logic [31:0] instr;
	logic        instr_valid;
	logic [4:0]  dbg_addr;
	logic        wb_valid;
	logic [4:0]  wb_addr;
	logic [31:0] wb_data;
	logic        illegal;
	logic [31:0] dbg_data;

	logic        exp_strobe;
	logic [31:0] exp_data;
	logic        dbg_strobe;
	int          errors;
	int          checks;
	int          pending;
	int          timeouts;

	// Stimulus table
	logic [31:0] instr_tab [0:31];
	logic        gap_tab [0:31];
	logic [31:0] exp_tab [0:31];
	int          n_entries;

	pipeline_top UUT (
		.clk         (clk),
		.rst         (rst),
		.init        (init),
		.instr       (instr),
		.instr_valid (instr_valid),
		.dbg_addr    (dbg_addr),
		.wb_valid    (wb_valid),
		.wb_addr     (wb_addr),
		.wb_data     (wb_data),
		.illegal     (illegal),
		.dbg_data    (dbg_data)
	);

	tb_checker u_checker (
		.clk        (clk),
		.rst        (rst),
		.init       (init),
		.instr      (instr),
		.exp_strobe (exp_strobe),
		.exp_data   (exp_data),
		.wb_valid   (wb_valid),
		.wb_addr    (wb_addr),
		.wb_data    (wb_data),
		.illegal    (illegal),
		.dbg_strobe (dbg_strobe),
		.dbg_addr   (dbg_addr),
		.dbg_data   (dbg_data),
		.errors     (errors),
		.checks     (checks),
		.pending    (pending)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	////////////////////
	// Encoders and table

	function automatic logic [31:0] rtype(input logic [5:0] fn, input logic [4:0] rs,
		input logic [4:0] rt, input logic [4:0] rd);
		return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic logic [31:0] itype(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	task automatic add_entry(input logic [31:0] ins, input logic gap, input logic [31:0] exp);
		instr_tab[n_entries] = ins;
		gap_tab[n_entries]   = gap;
		exp_tab[n_entries]   = exp;
		n_entries++;
	endtask

	// Expected values worked out from the preset bank
	task automatic build_table();
		n_entries = 0;
		// One of each operation, spaced apart
		add_entry(rtype(FN_ADD, 5'd3, 5'd5, 5'd16), 1'b1, 32'h0000_000a);
		add_entry(rtype(FN_SUB, 5'd2, 5'd3, 5'd17), 1'b1, 32'hffff_fffd);
		add_entry(rtype(FN_AND, 5'd8, 5'd3, 5'd18), 1'b1, 32'h0000_0001);
		add_entry(rtype(FN_OR, 5'd8, 5'd15, 5'd19), 1'b1, 32'h0000_0053);
		add_entry(rtype(FN_SLT, 5'd17, 5'd3, 5'd20), 1'b1, 32'h0000_0001);
		add_entry(rtype(FN_SLT, 5'd3, 5'd17, 5'd21), 1'b1, 32'h0000_0000);
		add_entry(itype(OP_ADDI, 5'd15, 5'd22, 16'hff9c), 1'b1, 32'hffff_ffec);
		add_entry(itype(OP_ANDI, 5'd17, 5'd23, 16'hff00), 1'b1, 32'h0000_ff00);
		add_entry(itype(OP_ORI, 5'd8, 5'd24, 16'h8000), 1'b1, 32'h0000_8003);
		// Back to back, forwarded on rs, rt and both
		add_entry(itype(OP_ADDI, 5'd3, 5'd25, 16'h0001), 1'b0, 32'h0000_0006);
		add_entry(rtype(FN_ADD, 5'd25, 5'd8, 5'd26), 1'b0, 32'h0000_0009);
		add_entry(rtype(FN_SUB, 5'd15, 5'd26, 5'd27), 1'b0, 32'h0000_0047);
		add_entry(rtype(FN_ADD, 5'd27, 5'd27, 5'd28), 1'b0, 32'h0000_008e);
		add_entry(rtype(FN_SLT, 5'd15, 5'd28, 5'd29), 1'b1, 32'h0000_0001);
		// Two apart, through the register file
		add_entry(itype(OP_ADDI, 5'd5, 5'd9, 16'h0007), 1'b0, 32'h0000_000c);
		add_entry(rtype(FN_OR, 5'd3, 5'd8, 5'd10), 1'b0, 32'h0000_0007);
		add_entry(rtype(FN_SUB, 5'd9, 5'd4, 5'd11), 1'b1, 32'h0000_000a);
		// Newer producer wins over the older one
		add_entry(itype(OP_ADDI, 5'd0, 5'd12, 16'h0001), 1'b0, 32'h0000_0003);
		add_entry(itype(OP_ADDI, 5'd12, 5'd12, 16'h0001), 1'b0, 32'h0000_0004);
		add_entry(rtype(FN_ADD, 5'd12, 5'd12, 5'd13), 1'b1, 32'h0000_0008);
		// Unknown opcode, then unknown function
		add_entry(itype(6'h3f, 5'd15, 5'd3, 16'h1234), 1'b1, 32'h0000_0000);
		add_entry(rtype(6'h3f, 5'd15, 5'd15, 5'd8), 1'b1, 32'h0000_0000);
	endtask

	////////////////////
	// Drive tasks

	task automatic pulse_init();
		@(posedge clk);
		init <= 1'b1;
		@(posedge clk);
		init <= 1'b0;
	endtask

	task automatic sweep_debug();
		for (int a = 0; a < 32; a++)
		begin
			@(posedge clk);
			dbg_addr   <= a[4:0];
			dbg_strobe <= 1'b1;
		end
		@(posedge clk);
		dbg_strobe <= 1'b0;
	endtask

	task automatic wait_drained();
		int n;
		n = 0;
		do
		begin
			@(negedge clk);
			n++;
		end
		while (pending != 0 && n < 20);
		if (pending != 0)
		begin
			$display("timeout while waiting for outstanding pulses");
			timeouts++;
		end
	endtask

	task automatic apply_table();
		int idle;
		for (int i = 0; i < n_entries; i++)
		begin
			@(posedge clk);
			instr       <= instr_tab[i];
			instr_valid <= 1'b1;
			exp_strobe  <= 1'b1;
			exp_data    <= exp_tab[i];
			if (gap_tab[i])
			begin
				@(posedge clk);
				instr_valid <= 1'b0;
				exp_strobe  <= 1'b0;
				idle = $urandom % 3;
				repeat (idle) @(posedge clk);
			end
		end
		@(posedge clk);
		instr_valid <= 1'b0;
		exp_strobe  <= 1'b0;
	endtask

	initial
	begin
		void'($urandom(32'h7dfa));
		rst         = 1'b1;
		init        = 1'b0;
		instr       = 32'd0;
		instr_valid = 1'b0;
		dbg_addr    = 5'd0;
		exp_strobe  = 1'b0;
		exp_data    = 32'd0;
		dbg_strobe  = 1'b0;
		timeouts    = 0;
		build_table();
		repeat (8) @(posedge clk);
		rst <= 1'b0;

		pulse_init();
		sweep_debug();
		apply_table();
		wait_drained();
		// Unknown codes must have left the bank alone
		sweep_debug();
		pulse_init();
		sweep_debug();

		repeat (3) @(posedge clk);
		$display("checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0 && checks > 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

//--- src.f
src/cpu_pkg.sv
src/register_file.sv
src/decode_stage.sv
src/execute_stage.sv
src/pipeline_top.sv
test/tb_checker.sv
test/tb_pipeline.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/10ps -j 0
TOP       = tb_pipeline
FILELIST  = src.f
OBJ_DIR   = obj_dir

SIM     = $(OBJ_DIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(OBJ_DIR)
